// File: common/ctrl_pkg.sv
// Pipeline controller package
// Shared widths, opcodes, pipeline slot structs and the trap entry address
`default_nettype none

package ctrl_pkg;

    localparam int WORD_W     = 32;                  // Data and PC width
    localparam int REG_ADDR_W = 5;                   // GPR index width
    localparam int HART_ID_W  = 2;                   // Up to four harts

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [HART_ID_W-1:0]  hart_id_t;

    ////////////////////////////////////////
    // Opcodes and codes
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        MEM_NOP = 4'b0000,
        MEM_SW  = 4'b0100,                           // Stores are 01xx
        MEM_SH  = 4'b0101,
        MEM_SB  = 4'b0110,
        MEM_LW  = 4'b1000,                           // Loads are 1xxx
        MEM_LH  = 4'b1001,
        MEM_LB  = 4'b1010,
        MEM_LHU = 4'b1011,
        MEM_LBU = 4'b1100
    } mem_op_e;

    typedef enum logic [2:0] {OP_ALU, OP_LD, OP_ST, OP_BR, OP_SYS} insn_op_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_EX, FWD_MEM} fwd_sel_e;

    typedef enum logic [2:0] {
        EXP_NO_EXP, EXP_ILLEGAL, EXP_MISALIGN, EXP_ECALL, EXP_BUS_ERR
    } exp_code_e;

    ////////////////////////////////////////
    // Pipeline slots
    ////////////////////////////////////////
    typedef struct packed {
        insn_op_e  op;                               // Instruction class in ID
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rs1_used;
        logic      rs2_used;
        hart_id_t  hart_id;
    } decode_slot_t;

    typedef struct packed {
        logic      en;                               // Slot holds a live insn
        hart_id_t  hart_id;
        reg_addr_t rd_addr;
        logic      gpr_we;                           // Active high
        mem_op_e   mem_op;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } exec_slot_t;

    typedef struct packed {
        logic if_s;
        logic id_s;
        logic ex_s;
        logic mem_s;
    } stage_vec_t;                                   // Per-stage stall or flush

    typedef struct packed {
        fwd_sel_e rs1_sel;
        fwd_sel_e rs2_sel;
        logic     st_rs1_en;                         // MEM load to EX store
        logic     st_rs2_en;
    } fwd_t;

    typedef struct packed {
        hart_id_t hart_id;
        word_t    addr;
    } miss_req_t;

    localparam word_t EXP_ENTRY_ADDR = 32'h0000_0100; // Unified trap entry

    function automatic logic is_load(input mem_op_e op);
        return op[3];
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op[3:2] == 2'b01;
    endfunction

endpackage

`default_nettype wire

// File: filelist.f
common/ctrl_pkg.sv
pipe_ctrl/pipeline_ctrl.sv
logic/exception_csr.sv
logic/miss_request_buffer.sv
logic/ctrl_top.sv
verification/ctrl_assertions.sv
verification/ctrl_tb.sv

// File: logic/ctrl_top.sv
// Pipeline control subsystem top
// Joins the controller, the per-hart trap registers and the miss buffer
`default_nettype none

module ctrl_top import ctrl_pkg::*; #(
    parameter int NUM_HARTS  = 4,
    parameter int MISS_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  decode_slot_t         dec,
    input  hart_id_t             if_hart_id,
    input  hart_id_t             issue_id,
    input  exec_slot_t           ex_slot,
    input  exec_slot_t           mem_slot,
    input  word_t                if_pc,
    input  word_t                ex_pc,
    input  word_t                mem_pc,
    input  exp_code_e            mem_exp,
    input  logic                 mem_is_eret,
    input  logic                 br_taken,
    input  logic                 ic_busy,
    input  logic                 dc_busy,
    input  logic                 hart_ic_stall,
    input  logic                 hart_ic_flush,
    input  logic                 hart_dc_flush,
    input  logic                 m_ready,    // Refill engine side
    input  hart_id_t             csr_rd_hart,
    output stage_vec_t           stall,
    output stage_vec_t           flush,
    output word_t                new_pc,
    output fwd_t                 fwd,
    output logic                 miss_ack,   // Back to hart control
    output logic                 m_valid,
    output miss_req_t            m_req,
    output word_t                csr_mepc,
    output exp_code_e            csr_mcause,
    output logic [NUM_HARTS-1:0] trap_active
);

    logic      save_exp;
    logic      restore_exp;
    exp_code_e exp_code;
    word_t     epc;
    word_t     mepc_rd;
    logic      miss_valid;
    miss_req_t miss_req;
    logic      miss_full;

    pipeline_ctrl u_pipeline_ctrl (
        .clk, .dec, .if_hart_id, .issue_id, .ex_slot, .mem_slot,
        .if_pc, .ex_pc, .mem_pc, .mem_exp, .mem_is_eret, .br_taken,
        .ic_busy, .dc_busy, .miss_full, .hart_ic_stall, .hart_ic_flush,
        .hart_dc_flush, .mepc_rd, .stall, .flush, .new_pc, .fwd,
        .miss_valid, .miss_req, .save_exp, .restore_exp, .exp_code, .epc
    );

    exception_csr #(
        .NUM_HARTS (NUM_HARTS)
    ) u_exception_csr (
        .clk, .rst_n, .save_exp, .restore_exp, .exp_code, .epc,
        .hart_id     (mem_slot.hart_id),     // Trap owner is the MEM hart
        .csr_rd_hart, .mepc_rd, .csr_mepc, .csr_mcause, .trap_active
    );

    miss_request_buffer #(
        .MISS_DEPTH (MISS_DEPTH)
    ) u_miss_request_buffer (
        .clk, .rst_n, .miss_valid, .miss_req, .m_ready,
        .miss_full, .miss_ack, .m_valid, .m_req
    );

endmodule

`default_nettype wire

// File: logic/exception_csr.sv
// Per-hart trap registers
// Saved PC, cause and trap-active flag, written on trap entry and return
`default_nettype none

module exception_csr import ctrl_pkg::*; #(
    parameter int NUM_HARTS = 4              // At most 2**HART_ID_W
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 save_exp,
    input  logic                 restore_exp,
    input  exp_code_e            exp_code,
    input  word_t                epc,
    input  hart_id_t             hart_id,    // Hart in MEM
    input  hart_id_t             csr_rd_hart, // CSR read port select
    output word_t                mepc_rd,
    output word_t                csr_mepc,
    output exp_code_e            csr_mcause,
    output logic [NUM_HARTS-1:0] trap_active
);

    word_t     mepc   [NUM_HARTS];
    exp_code_e mcause [NUM_HARTS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                mepc[h]   <= '0;
                mcause[h] <= EXP_NO_EXP;
            end
            trap_active <= '0;
        end else if (save_exp) begin
            mepc[hart_id]        <= epc;
            mcause[hart_id]      <= exp_code;
            trap_active[hart_id] <= 1'b1;    // Hart now in its handler
        end else if (restore_exp) begin
            trap_active[hart_id] <= 1'b0;
        end
    end

    // Combinational reads
    assign mepc_rd    = mepc[hart_id];       // Feeds the eret redirect
    assign csr_mepc   = mepc[csr_rd_hart];
    assign csr_mcause = mcause[csr_rd_hart];

endmodule

`default_nettype wire

// File: logic/miss_request_buffer.sv
// Cache miss request FIFO
// Takes miss reports from the controller and hands them to the refill engine
`default_nettype none

module miss_request_buffer import ctrl_pkg::*; #(
    parameter int MISS_DEPTH = 2
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      miss_valid,
    input  miss_req_t miss_req,
    input  logic      m_ready,
    output logic      miss_full,
    output logic      miss_ack,              // Push accepted this cycle
    output logic      m_valid,
    output miss_req_t m_req
);

    localparam int PTR_W = (MISS_DEPTH > 1) ? $clog2(MISS_DEPTH) : 1;
    localparam int CNT_W = $clog2(MISS_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST  = PTR_W'(MISS_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH = CNT_W'(MISS_DEPTH);

    miss_req_t        mem [MISS_DEPTH];      // Request storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push      = miss_valid & ~miss_full;
    assign pop       = m_valid & m_ready;    // Refill engine handshake
    assign miss_full = (count == DEPTH);
    assign miss_ack  = push;
    assign m_valid   = (count != '0);
    assign m_req     = mem[rd_ptr];          // Oldest entry at the head

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= miss_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: pipe_ctrl/pipeline_ctrl.sv
// Central pipeline controller of the multi-hart core
// Forwarding, load-use hazard, stall and flush, trap redirect, miss select
`default_nettype none

module pipeline_ctrl import ctrl_pkg::*; (
    input  logic         clk,                // Sampled by bound checks only
    input  decode_slot_t dec,                // Instruction in ID
    input  hart_id_t     if_hart_id,         // Hart of the ID instruction
    input  hart_id_t     issue_id,           // Hart being fetched
    input  exec_slot_t   ex_slot,
    input  exec_slot_t   mem_slot,
    input  word_t        if_pc,
    input  word_t        ex_pc,
    input  word_t        mem_pc,
    input  exp_code_e    mem_exp,
    input  logic         mem_is_eret,
    input  logic         br_taken,
    input  logic         ic_busy,
    input  logic         dc_busy,
    input  logic         miss_full,          // Miss buffer cannot accept
    input  logic         hart_ic_stall,
    input  logic         hart_ic_flush,
    input  logic         hart_dc_flush,
    input  word_t        mepc_rd,            // Saved PC of MEM hart
    output stage_vec_t   stall,
    output stage_vec_t   flush,
    output word_t        new_pc,
    output fwd_t         fwd,
    output logic         miss_valid,
    output miss_req_t    miss_req,
    output logic         save_exp,
    output logic         restore_exp,
    output exp_code_e    exp_code,
    output word_t        epc
);

    logic busy;                              // Any storage side stall
    logic ld_hazard;
    logic trap_flush;                        // Exception flushes everything
    logic eret_flush;
    logic br_flush_id;
    logic dc_flush_id;
    logic dc_flush_ex;

    // Producer hit check, EX wins over MEM
    function automatic fwd_sel_e src_fwd(input logic used, input reg_addr_t rs);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (used && rs != '0) begin
            if (ex_slot.en && ex_slot.gpr_we && ex_slot.hart_id == if_hart_id &&
                ex_slot.rd_addr == rs) begin
                sel = FWD_EX;
            end else if (mem_slot.en && mem_slot.gpr_we &&
                         mem_slot.hart_id == if_hart_id && mem_slot.rd_addr == rs) begin
                sel = FWD_MEM;
            end
        end
        return sel;
    endfunction

    // Load data in MEM feeding store data in EX
    function automatic logic st_fwd(input reg_addr_t rs);
        return mem_slot.en && mem_slot.gpr_we && is_load(mem_slot.mem_op) &&
               ex_slot.en && is_store(ex_slot.mem_op) && rs != '0 &&
               mem_slot.hart_id == ex_slot.hart_id && mem_slot.rd_addr == rs;
    endfunction

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////
    always_comb begin
        fwd.rs1_sel   = src_fwd(dec.rs1_used, dec.rs1);
        fwd.rs2_sel   = src_fwd(dec.rs2_used, dec.rs2);
        fwd.st_rs1_en = st_fwd(ex_slot.rs1);
        fwd.st_rs2_en = st_fwd(ex_slot.rs2);
    end

    ////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////
    always_comb begin
        ld_hazard = 1'b0;
        if (ex_slot.en && ex_slot.gpr_we && is_load(ex_slot.mem_op) &&
            ex_slot.hart_id == if_hart_id) begin
            // Store data can wait for the MEM to EX path, base cannot
            if (dec.op != OP_ST || ex_slot.rd_addr == dec.rs1) begin
                ld_hazard = (dec.rs1_used && ex_slot.rd_addr == dec.rs1) ||
                            (dec.rs2_used && ex_slot.rd_addr == dec.rs2);
            end
        end
    end

    ////////////////////////////////////////
    // Trap entry and return
    ////////////////////////////////////////
    always_comb begin
        new_pc      = '0;
        trap_flush  = 1'b0;
        eret_flush  = 1'b0;
        save_exp    = 1'b0;
        restore_exp = 1'b0;
        exp_code    = EXP_NO_EXP;
        epc         = '0;
        if (mem_slot.en) begin
            if (mem_exp != EXP_NO_EXP) begin
                new_pc     = EXP_ENTRY_ADDR;     // Single entry for all causes
                trap_flush = 1'b1;
                save_exp   = 1'b1;
                exp_code   = mem_exp;
                epc        = mem_pc;
            end else if (mem_is_eret) begin
                new_pc      = mepc_rd;           // Back to the faulting insn
                eret_flush  = 1'b1;
                restore_exp = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Stall and flush vectors
    ////////////////////////////////////////
    assign busy        = ic_busy | dc_busy | miss_full;
    assign br_flush_id = br_taken & (ex_slot.hart_id == if_hart_id);
    assign dc_flush_id = hart_dc_flush & (mem_slot.hart_id == if_hart_id);
    assign dc_flush_ex = hart_dc_flush & (mem_slot.hart_id == ex_slot.hart_id);

    assign stall.if_s  = ld_hazard | hart_dc_flush | busy;
    assign stall.id_s  = hart_dc_flush | busy;
    assign stall.ex_s  = hart_dc_flush | busy;
    assign stall.mem_s = busy;               // MEM only waits on storage

    assign flush.if_s  = trap_flush | eret_flush;
    assign flush.id_s  = trap_flush | ld_hazard | br_flush_id | dc_flush_id;
    assign flush.ex_s  = trap_flush | dc_flush_ex;
    assign flush.mem_s = trap_flush | hart_dc_flush;

    ////////////////////////////////////////
    // Cache miss report
    ////////////////////////////////////////
    always_comb begin
        miss_valid = 1'b0;
        miss_req   = '0;
        if (hart_dc_flush) begin             // Data side first
            miss_valid       = 1'b1;
            miss_req.hart_id = mem_slot.hart_id;
            miss_req.addr    = ex_pc;
        end else if (hart_ic_stall | hart_ic_flush) begin
            miss_valid       = 1'b1;
            miss_req.hart_id = issue_id;
            miss_req.addr    = if_pc;
        end
    end

endmodule

`default_nettype wire

// File: verification/ctrl_assertions.sv
// Bound checks for the pipeline control subsystem
// Trap entry redirect, miss request stability and full-buffer acceptance
`default_nettype none

module ctrl_assertions import ctrl_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       save_exp,
    input word_t      new_pc,
    input stage_vec_t flush,
    input logic       m_valid,
    input logic       m_ready,
    input miss_req_t  m_req,
    input logic       miss_ack,
    input logic       miss_full
);

    // Trap entry redirects to the single vector and clears the pipe
    a_trap_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        save_exp |-> (new_pc == EXP_ENTRY_ADDR && flush == 4'b1111))
        else $error("trap entry without full flush and vector redirect");

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (m_valid && !m_ready) |=> $stable(m_req))
        else $error("miss request changed while stalled");

    // A full buffer without a pop stays full and refuses new misses
    a_no_ack_full: assert property (@(posedge clk) disable iff (!rst_n)
        (miss_full && !m_ready) |=> (miss_full && !miss_ack))
        else $error("miss accepted while buffer full");

endmodule

// Both the controller and the miss buffer signals are visible here
bind ctrl_top ctrl_assertions u_ctrl_assertions (.*);

`default_nettype wire

// File: verification/ctrl_tb.sv
// Pipeline control subsystem testbench
// Random and directed stimulus checked against a reference model and FIFO model
`default_nettype none

module ctrl_tb import ctrl_pkg::*; ();

    typedef struct packed {
        stage_vec_t stall;
        stage_vec_t flush;
        fwd_t       fwd;
        word_t      new_pc;
    } expect_t;

    logic         clk;
    logic         rst_n;
    decode_slot_t dec;
    hart_id_t     if_hart_id;
    hart_id_t     issue_id;
    exec_slot_t   ex_slot;
    exec_slot_t   mem_slot;
    word_t        if_pc;
    word_t        ex_pc;
    word_t        mem_pc;
    exp_code_e    mem_exp;
    logic         mem_is_eret;
    logic         br_taken;
    logic         ic_busy;
    logic         dc_busy;
    logic         hart_ic_stall;
    logic         hart_ic_flush;
    logic         hart_dc_flush;
    logic         m_ready;
    hart_id_t     csr_rd_hart;
    stage_vec_t   stall;
    stage_vec_t   flush;
    word_t        new_pc;
    fwd_t         fwd;
    logic         miss_ack;
    logic         m_valid;
    miss_req_t    m_req;
    word_t        csr_mepc;
    exp_code_e    csr_mcause;
    logic [3:0]   trap_active;

    logic [31:0]  rng = 32'h94dd0d7d;       // xorshift state
    int           err_count;
    int           check_count;
    int           cycles;
    string        test_name;
    miss_req_t    fifo_q[$];                 // Expected miss buffer contents
    word_t        mepc_model [4];
    exp_code_e    cause_model [4];
    logic [3:0]   active_model;

    ctrl_top #(.NUM_HARTS(4), .MISS_DEPTH(2)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit near twice the test length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic fwd_sel_e pick_src(input logic used, input reg_addr_t rs);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = ex_slot.en && ex_slot.gpr_we && ex_slot.hart_id == if_hart_id &&
                  ex_slot.rd_addr == rs;
        mem_hit = mem_slot.en && mem_slot.gpr_we && mem_slot.hart_id == if_hart_id &&
                  mem_slot.rd_addr == rs;
        if (!used || rs == 5'd0) return FWD_NONE;
        if (ex_hit) return FWD_EX;           // Younger producer first
        if (mem_hit) return FWD_MEM;
        return FWD_NONE;
    endfunction

    function automatic logic store_src_hit(input reg_addr_t rs);
        logic ld_mem;
        logic st_ex;
        ld_mem = mem_slot.en && mem_slot.mem_op inside {MEM_LW, MEM_LH, MEM_LB, MEM_LHU, MEM_LBU};
        st_ex  = ex_slot.en && ex_slot.mem_op inside {MEM_SW, MEM_SH, MEM_SB};
        return ld_mem && st_ex && rs != 5'd0 && mem_slot.hart_id == ex_slot.hart_id &&
               mem_slot.rd_addr == rs;
    endfunction

    function automatic expect_t ref_model(input logic full);
        expect_t e;
        logic    busy;
        logic    hazard;
        logic    trap;
        logic    eret;
        e      = '0;
        busy   = ic_busy | dc_busy | full;
        hazard = ex_slot.en && ex_slot.gpr_we && ex_slot.hart_id == if_hart_id &&
                 ex_slot.mem_op inside {MEM_LW, MEM_LH, MEM_LB, MEM_LHU, MEM_LBU};
        if (dec.op == OP_ST) begin
            hazard = hazard && dec.rs1_used && ex_slot.rd_addr == dec.rs1; // Base only
        end else begin
            hazard = hazard && ((dec.rs1_used && ex_slot.rd_addr == dec.rs1) ||
                                (dec.rs2_used && ex_slot.rd_addr == dec.rs2));
        end
        e.fwd.rs1_sel   = pick_src(dec.rs1_used, dec.rs1);
        e.fwd.rs2_sel   = pick_src(dec.rs2_used, dec.rs2);
        e.fwd.st_rs1_en = store_src_hit(ex_slot.rs1);
        e.fwd.st_rs2_en = store_src_hit(ex_slot.rs2);
        trap = mem_slot.en && mem_exp != EXP_NO_EXP;
        eret = mem_slot.en && !trap && mem_is_eret;
        if (trap) e.new_pc = EXP_ENTRY_ADDR;
        else if (eret) e.new_pc = mepc_model[mem_slot.hart_id];
        e.stall.if_s  = hazard | hart_dc_flush | busy;
        e.stall.id_s  = hart_dc_flush | busy;
        e.stall.ex_s  = hart_dc_flush | busy;
        e.stall.mem_s = busy;
        e.flush.if_s  = trap | eret;
        e.flush.id_s  = trap | hazard | (br_taken && ex_slot.hart_id == if_hart_id) |
                        (hart_dc_flush && mem_slot.hart_id == if_hart_id);
        e.flush.ex_s  = trap | (hart_dc_flush && mem_slot.hart_id == ex_slot.hart_id);
        e.flush.mem_s = trap | hart_dc_flush;
        return e;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_vec(input string name, input stage_vec_t exp, input stage_vec_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_fwd(input string name, input fwd_t exp, input fwd_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_req(input string name, input miss_req_t exp, input miss_req_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input exp_code_e exp, input exp_code_e act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Error: %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_bits(input string name, input logic [3:0] exp, input logic [3:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Scoreboard sampled before each rising edge
    ////////////////////////////////////////
    task automatic compare_cycle();
        expect_t   e;
        logic      full;
        logic      exp_push;
        miss_req_t exp_req;
        full = (fifo_q.size() == 2);
        e    = ref_model(full);
        check_vec({test_name, " stall"}, e.stall, stall);
        check_vec({test_name, " flush"}, e.flush, flush);
        check_fwd({test_name, " fwd"}, e.fwd, fwd);
        check_word({test_name, " new_pc"}, e.new_pc, new_pc);
        check_word({test_name, " csr_mepc"}, mepc_model[csr_rd_hart], csr_mepc);
        check_cause({test_name, " csr_mcause"}, cause_model[csr_rd_hart], csr_mcause);
        check_bits({test_name, " trap_active"}, active_model, trap_active);
        check_bits({test_name, " m_valid"}, {3'b0, fifo_q.size() != 0}, {3'b0, m_valid});
        if (m_valid && m_ready && fifo_q.size() != 0) begin
            check_req({test_name, " m_req"}, fifo_q[0], m_req);
            void'(fifo_q.pop_front());
        end
        exp_push = 1'b0;
        exp_req  = '0;
        if (hart_dc_flush) begin            // Data side wins
            exp_push = !full;
            exp_req  = '{hart_id: mem_slot.hart_id, addr: ex_pc};
        end else if (hart_ic_stall || hart_ic_flush) begin
            exp_push = !full;
            exp_req  = '{hart_id: issue_id, addr: if_pc};
        end
        check_bits({test_name, " miss_ack"}, {3'b0, exp_push}, {3'b0, miss_ack});
        if (exp_push) fifo_q.push_back(exp_req);
        if (mem_slot.en && mem_exp != EXP_NO_EXP) begin
            mepc_model[mem_slot.hart_id]   = mem_pc;
            cause_model[mem_slot.hart_id]  = mem_exp;
            active_model[mem_slot.hart_id] = 1'b1;
        end else if (mem_slot.en && mem_is_eret) begin
            active_model[mem_slot.hart_id] = 1'b0;
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            #45;
            if (rst_n) compare_cycle();
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    task automatic idle_inputs();
        dec = '{op: OP_ALU, rs1: 5'd0, rs2: 5'd0, rs1_used: 1'b0, rs2_used: 1'b0,
                hart_id: 2'd0};
        if_hart_id    = 2'd0;
        issue_id      = 2'd0;
        ex_slot       = '{en: 1'b0, hart_id: 2'd0, rd_addr: 5'd0, gpr_we: 1'b0,
                          mem_op: MEM_NOP, rs1: 5'd0, rs2: 5'd0};
        mem_slot      = ex_slot;
        mem_exp       = EXP_NO_EXP;
        mem_is_eret   = 1'b0;
        br_taken      = 1'b0;
        ic_busy       = 1'b0;
        dc_busy       = 1'b0;
        hart_ic_stall = 1'b0;
        hart_ic_flush = 1'b0;
        hart_dc_flush = 1'b0;
    endtask

    function automatic exec_slot_t make_slot(input logic [1:0] h, input reg_addr_t rd,
                                             input mem_op_e op, input reg_addr_t r1,
                                             input reg_addr_t r2);
        exec_slot_t s;
        s = '{en: 1'b1, hart_id: h, rd_addr: rd, gpr_we: !(op inside {MEM_SW, MEM_SH, MEM_SB}),
              mem_op: op, rs1: r1, rs2: r2};
        return s;
    endfunction

    function automatic exec_slot_t rand_slot();
        logic [31:0] r;
        mem_op_e     op;
        r  = next_rand();
        op = (r[9:8] == 2'd0) ? MEM_NOP : (r[9:8] == 2'd1) ? MEM_LW :
             (r[9:8] == 2'd2) ? MEM_SW : MEM_LBU;
        return make_slot({1'b0, r[2]}, reg_addr_t'(r[5:4]), op,
                         reg_addr_t'(r[12:11]), reg_addr_t'(r[14:13]));
    endfunction

    initial begin
        logic [31:0] r;
        rst_n       = 1'b0;
        m_ready     = 1'b0;
        csr_rd_hart = 2'd0;
        if_pc       = '0;
        ex_pc       = '0;
        mem_pc      = '0;
        err_count   = 0;
        check_count = 0;
        cycles      = 0;
        test_name   = "reset";
        active_model = '0;
        for (int h = 0; h < 4; h++) begin
            mepc_model[h]  = '0;
            cause_model[h] = EXP_NO_EXP;
        end
        idle_inputs();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        repeat (400) begin
            @(negedge clk);
            test_name = "forwarding";
            idle_inputs();
            r        = next_rand();
            ex_slot  = rand_slot();
            mem_slot = rand_slot();
            ex_slot.en  = r[20] | r[21];
            mem_slot.en = r[22] | r[23];
            dec = '{op: insn_op_e'(r[2:0] % 5), rs1: reg_addr_t'(r[4:3]),
                    rs2: reg_addr_t'(r[6:5]), rs1_used: r[7], rs2_used: r[8],
                    hart_id: {1'b0, r[9]}};
            if (dec.op == OP_ST) dec.rs1_used = 1'b1; // Stores always read a base
            if_hart_id = dec.hart_id;
            br_taken   = r[10] & r[11];
        end

        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            test_name  = "load_use";
            idle_inputs();
            ex_slot    = make_slot((k == 3) ? 2'd2 : 2'd1, 5'd5, MEM_LW, 5'd1, 5'd2);
            dec        = '{op: (k == 0) ? OP_ALU : OP_ST, rs1: (k == 2) ? 5'd6 : 5'd5,
                           rs2: 5'd5, rs1_used: 1'b1, rs2_used: 1'b1, hart_id: 2'd1};
            if_hart_id = 2'd1;
        end
        @(negedge clk);                     // Store data served by MEM to EX path
        idle_inputs();
        mem_slot = make_slot(2'd1, 5'd7, MEM_LW, 5'd1, 5'd2);
        ex_slot  = make_slot(2'd1, 5'd0, MEM_SW, 5'd3, 5'd7);

        @(negedge clk);
        test_name = "exception";
        idle_inputs();
        mem_slot    = make_slot(2'd2, 5'd4, MEM_NOP, 5'd1, 5'd1);
        mem_exp     = EXP_ECALL;
        mem_pc      = 32'h0000_2468;
        csr_rd_hart = 2'd2;
        @(negedge clk);
        idle_inputs();
        check_bits("exception trap_active", 4'b0100, trap_active);
        check_word("exception mepc", 32'h0000_2468, csr_mepc);

        test_name = "eret";
        mem_slot    = make_slot(2'd2, 5'd0, MEM_NOP, 5'd0, 5'd0);
        mem_is_eret = 1'b1;
        @(negedge clk);
        mem_slot.hart_id = 2'd3;             // Hart with no saved PC
        @(negedge clk);
        idle_inputs();
        check_bits("eret trap_active", 4'b0000, trap_active);

        repeat (600) begin
            @(negedge clk);
            test_name     = "miss_random";
            idle_inputs();
            r             = next_rand();
            ex_slot       = rand_slot();
            mem_slot      = rand_slot();
            issue_id      = hart_id_t'(r[1:0]);
            if_pc         = {r[31:8], 8'h00};
            ex_pc         = {8'h00, r[27:4]};
            hart_dc_flush = (r[4:2] == 3'd0);
            hart_ic_stall = (r[7:5] == 3'd1);
            hart_ic_flush = (r[10:8] == 3'd2);
            m_ready       = r[11] | r[12];
        end

        @(negedge clk);
        test_name = "miss_full";
        idle_inputs();
        m_ready = 1'b1;
        repeat (3) @(negedge clk);
        m_ready = 1'b0;
        for (int k = 0; k < 4; k++) begin
            hart_ic_stall = 1'b1;
            if_pc         = 32'h0000_1000 + 32'(k * 4);
            @(negedge clk);
        end
        check_vec("miss_full stall", 4'b1111, stall);
        hart_ic_stall = 1'b0;
        m_ready       = 1'b1;
        repeat (3) @(negedge clk);

        test_name = "busy_branch";
        idle_inputs();
        m_ready = 1'b0;
        ic_busy = 1'b1;
        @(negedge clk);
        ic_busy = 1'b0;
        dc_busy = 1'b1;
        @(negedge clk);
        idle_inputs();
        br_taken        = 1'b1;
        ex_slot.hart_id = 2'd1;
        if_hart_id      = 2'd1;
        @(negedge clk);
        if_hart_id = 2'd2;
        @(negedge clk);
        idle_inputs();
        @(negedge clk);

        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
